/* verilog.f */
+incdir+hdl
hdl/uart_cmd_pkg.sv
hdl/uart_frame_tx.sv
hdl/uart_frame_rx.sv
hdl/uart_cmd_ctrl.sv
hdl/uart_cmd_top.sv
bench/uart_cmd_asserts.sv
bench/uart_cmd_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module uart_cmd_tb -f verilog.f &&
./obj_dir/Vuart_cmd_tb | tee /dev/stderr | grep -q "^Simulation passed$" ||
{ echo "UART bridge run did not pass"; exit 1; }

/* bench/uart_cmd_tb.sv */
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_cmd_tb import uart_cmd_pkg::*; ();

  localparam int NUM_CMDS       = 200;
  localparam int TIMEOUT_CYCLES = 250000;  // About 1,000 cycles per command.
  localparam logic [1:0] FAULT_NONE   = 2'd0;
  localparam logic [1:0] FAULT_PARITY = 2'd1;
  localparam logic [1:0] FAULT_STOP   = 2'd2;
  localparam logic [1:0] FAULT_SILENT = 2'd3;

  logic  clk;
  logic  rst_n;
  logic  cmd_valid;
  logic  cmd_ready;
  cmd_t  cmd_data;
  logic  rsp_valid;
  logic  rsp_ready;
  byte_t rsp_data;
  logic  rsp_parity_err;
  logic  rsp_frame_err;
  logic  rsp_timeout;
  logic  rx;
  logic  tx;

  logic [31:0] rng_state = 32'h3571fd46;
  int          errors    = 0;
  int          checks    = 0;
  int          cycle_cnt = 0;
  logic        dev_busy  = 1'b0;  // Device still answering a read.

  byte_t      model_regs [128];  // Expected register contents.
  byte_t      dev_regs   [128];
  byte_t      exp_tx_q   [$];
  logic [1:0] fault_q    [$];
  logic [6:0] delay_q    [$];

  uart_cmd_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_data       (cmd_data),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp_data       (rsp_data),
    .rsp_parity_err (rsp_parity_err),
    .rsp_frame_err  (rsp_frame_err),
    .rsp_timeout    (rsp_timeout),
    .rx             (rx),
    .tx             (tx)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("Timeout: the commands did not complete within %0d cycles.", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic byte_t fill_value(input reg_addr_t a);
    return {a, ~a[6]} ^ 8'h5a;
  endfunction

  task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Samples tx in the middle of each bit.
  task automatic take_frame(output byte_t b);
    logic par;
    logic stp;
    do
      @(negedge clk);
    while (tx !== 1'b0);
    repeat (`UART_BAUD_DIV / 2) @(negedge clk);
    check_value(16'(tx), 16'd0, "tx start bit");
    for (int i = 0; i < 8; i++)
    begin
      repeat (`UART_BAUD_DIV) @(negedge clk);
      b[i] = tx;  // LSB first.
    end
    repeat (`UART_BAUD_DIV) @(negedge clk);
    par = tx;
    repeat (`UART_BAUD_DIV) @(negedge clk);
    stp = tx;
    check_value(16'(^{b, par}), 16'd1, "tx odd parity");
    check_value(16'(stp), 16'd1, "tx stop bit");
    if (exp_tx_q.size() == 0)
    begin
      errors++;
      $display("Frame %h appeared on tx at %0t with no command pending.", b, $time);
    end
    else
      check_value(16'(b), 16'(exp_tx_q.pop_front()), "tx byte");
  endtask

  task automatic send_frame(input byte_t d, input logic [1:0] fault);
    logic [10:0] bits;
    bits = {1'b1, ~^d, d, 1'b0};
    if (fault == FAULT_PARITY)
      bits[9] = ^d;
    if (fault == FAULT_STOP)
      bits[10] = 1'b0;
    for (int i = 0; i < 11; i++)
    begin
      @(posedge clk);
      rx <= bits[i];
      repeat (`UART_BAUD_DIV - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;
  endtask

  task automatic send_command(input cmd_t c);
    while (dev_busy)
      @(negedge clk);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_data  <= c;
    do
    begin
      @(negedge clk);
      check_value(16'(rsp_valid), 16'd0, "rsp_valid with no read pending");
    end
    while (cmd_ready !== 1'b1);
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic check_response(input byte_t d, input logic pe, input logic fe, input logic to);
    check_value(16'(rsp_valid), 16'd1, "rsp_valid");
    check_value(16'(cmd_ready), 16'd0, "cmd_ready during response");
    check_value(16'(rsp_data), 16'(d), "rsp_data");
    check_value(16'(rsp_parity_err), 16'(pe), "rsp_parity_err");
    check_value(16'(rsp_frame_err), 16'(fe), "rsp_frame_err");
    check_value(16'(rsp_timeout), 16'(to), "rsp_timeout");
  endtask

  task automatic get_response(input byte_t d, input logic pe, input logic fe, input logic to,
                              input logic [2:0] stall);
    do
      @(negedge clk);
    while (rsp_valid !== 1'b1);
    check_response(d, pe, fe, to);
    repeat (stall)
    begin
      @(negedge clk);
      check_response(d, pe, fe, to);
    end
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(posedge clk);
    rsp_ready <= 1'b0;
  endtask

  // Remote device.
  initial
  begin : remote_device
    byte_t      hi;
    byte_t      lo;
    logic [1:0] fault;
    logic [6:0] delay;
    rx <= 1'b1;
    wait (rst_n === 1'b1);
    forever
    begin
      take_frame(hi);
      if (hi[7])
      begin
        take_frame(lo);
        dev_regs[hi[6:0]] = lo;
      end
      else if (fault_q.size() == 0)
      begin
        errors++;
        $display("Read frame on tx at %0t without a matching read command.", $time);
      end
      else
      begin
        dev_busy = 1'b1;
        fault    = fault_q.pop_front();
        delay    = delay_q.pop_front();
        if (fault != FAULT_SILENT)
        begin
          repeat (delay) @(posedge clk);
          send_frame(dev_regs[hi[6:0]], fault);
        end
        dev_busy = 1'b0;
      end
    end
  end

  initial
  begin
    logic [31:0] r1;
    logic [31:0] r2;
    reg_addr_t   addr;
    byte_t       data;
    logic [1:0]  fault;
    byte_t       exp_data;
    rst_n     <= 1'b0;
    cmd_valid <= 1'b0;
    cmd_data  <= '0;
    rsp_ready <= 1'b0;
    for (int a = 0; a < 128; a++)
    begin
      model_regs[a] = fill_value(reg_addr_t'(a));
      dev_regs[a]   = fill_value(reg_addr_t'(a));
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value(16'(tx), 16'd1, "tx after reset");
    check_value(16'(cmd_ready), 16'd1, "cmd_ready after reset");
    check_value(16'(rsp_valid), 16'd0, "rsp_valid after reset");

    for (int n = 0; n < NUM_CMDS; n++)
    begin
      r1   = next_rand();
      r2   = next_rand();
      addr = r1[30] ? r1[29:23] : {3'b000, r1[26:23]};  // Favor a few addresses.
      data = r1[22:15];
      if (r1[31])
      begin
        model_regs[addr] = data;
        exp_tx_q.push_back({1'b1, addr});
        exp_tx_q.push_back(data);
        send_command({1'b1, addr, data});
      end
      else
      begin
        case (r2[31:29])
          3'd5: fault = FAULT_PARITY;
          3'd6: fault = FAULT_STOP;
          3'd7: fault = FAULT_SILENT;
          default: fault = FAULT_NONE;
        endcase
        exp_data = (fault == FAULT_SILENT) ? 8'h00 : model_regs[addr];
        exp_tx_q.push_back({1'b0, addr});
        fault_q.push_back(fault);
        delay_q.push_back(r2[28:22]);
        send_command({1'b0, addr, data});  // Low byte stays off the line.
        get_response(exp_data, fault == FAULT_PARITY, fault == FAULT_STOP,
                     fault == FAULT_SILENT, r2[21:19]);
      end
    end

    do
      @(negedge clk);
    while (!cmd_ready || dev_busy || exp_tx_q.size() != 0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* bench/uart_cmd_asserts.sv */
`timescale 1ns/10ps

module uart_cmd_asserts import uart_cmd_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  cmd_ready,
  input logic  rsp_valid,
  input logic  rsp_ready,
  input byte_t rsp_data,
  input logic  rsp_parity_err,
  input logic  rsp_frame_err,
  input logic  rsp_timeout,
  input logic  tx
);

  // Response held while the host stalls.
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_parity_err)
      && $stable(rsp_frame_err) && $stable(rsp_timeout))
    else $error("response changed while rsp_ready was low");

  // A taken response frees the bridge for the next command.
  rsp_taken: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |=> !rsp_valid && cmd_ready)
    else $error("bridge not idle after the response was taken");

  idle_line: assert property (@(posedge clk) disable iff (!rst_n) cmd_ready |-> tx)
    else $error("tx low while the bridge is idle");

  reset_state: assert property (@(posedge clk) $rose(rst_n) |-> tx && cmd_ready && !rsp_valid)
    else $error("wrong output levels after reset");

endmodule

bind uart_cmd_top uart_cmd_asserts u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .cmd_ready      (cmd_ready),
  .rsp_valid      (rsp_valid),
  .rsp_ready      (rsp_ready),
  .rsp_data       (rsp_data),
  .rsp_parity_err (rsp_parity_err),
  .rsp_frame_err  (rsp_frame_err),
  .rsp_timeout    (rsp_timeout),
  .tx             (tx)
);

/* hdl/uart_cmd_top.sv */
`timescale 1ns/10ps

interface rx_byte_if import uart_cmd_pkg::*; ();
  logic  valid;  // One-cycle pulse per frame.
  byte_t data;
  logic  parity_err;
  logic  frame_err;

  modport source (output valid, output data, output parity_err, output frame_err);
  modport sink   (input valid, input data, input parity_err, input frame_err);
endinterface

module uart_cmd_top import uart_cmd_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  cmd_valid,
  output logic  cmd_ready,
  input  cmd_t  cmd_data,
  output logic  rsp_valid,
  input  logic  rsp_ready,
  output byte_t rsp_data,
  output logic  rsp_parity_err,
  output logic  rsp_frame_err,
  output logic  rsp_timeout,
  input  logic  rx,
  output logic  tx
);

  logic  tx_valid;
  logic  tx_ready;
  byte_t tx_byte;

  rx_byte_if rx_bus ();

  uart_cmd_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid      (cmd_valid),
    .cmd_data       (cmd_data),
    .cmd_ready      (cmd_ready),
    .rsp_ready      (rsp_ready),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .rsp_parity_err (rsp_parity_err),
    .rsp_frame_err  (rsp_frame_err),
    .rsp_timeout    (rsp_timeout),
    .tx_valid       (tx_valid),
    .tx_byte        (tx_byte),
    .tx_ready       (tx_ready),
    .rx_in          (rx_bus.sink)
  );

  uart_frame_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_valid (tx_valid),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_frame_rx u_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rx_out (rx_bus.source)
  );

endmodule

/* hdl/uart_cmd_ctrl.sv */
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_cmd_ctrl import uart_cmd_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_valid,
  input  cmd_t      cmd_data,
  output logic      cmd_ready,
  input  logic      rsp_ready,
  output logic      rsp_valid,
  output byte_t     rsp_data,
  output logic      rsp_parity_err,
  output logic      rsp_frame_err,
  output logic      rsp_timeout,
  output logic      tx_valid,
  output byte_t     tx_byte,
  input  logic      tx_ready,
  rx_byte_if.sink   rx_in
);

  localparam wait_cnt_t GAP_LAST   = wait_cnt_t'(`UART_GAP_CYCLES - 1);
  localparam wait_cnt_t RSP_LAST   = wait_cnt_t'(`UART_RESP_TIMEOUT - 1);
  // A frame started just before the timeout still needs a frame time to land.
  localparam wait_cnt_t GRACE_LAST = wait_cnt_t'(11 * `UART_BAUD_DIV - 1);

  ctrl_state_t state;
  wait_cnt_t   wait_cnt;
  cmd_t        cmd_q;
  reg_addr_t   cmd_addr;
  logic        is_write;
  logic        rx_take;
  logic        grace_end;

  assign cmd_addr  = cmd_q[14:8];
  assign is_write  = cmd_q[15];
  assign rx_take   = rx_in.valid && (state == WAIT_RSP || state == RECV);
  assign grace_end = (state == RECV) && (wait_cnt == GRACE_LAST);

  assign cmd_ready = (state == IDLE);
  assign rsp_valid = (state == RESPOND);
  assign tx_valid  = (state == SEND_HI) || (state == SEND_LO);
  assign tx_byte   = (state == SEND_HI) ? {is_write, cmd_addr} : cmd_q[7:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (cmd_valid)
            state <= SEND_HI;
        SEND_HI:
          if (tx_ready)
          begin
            state    <= GAP_HI;
            wait_cnt <= '0;
          end
        SEND_LO:
          if (tx_ready)
          begin
            state    <= GAP_LO;
            wait_cnt <= '0;
          end
        GAP_HI, GAP_LO:
        begin
          // Gap counts only once the frame has left the line.
          if (!tx_ready)
            wait_cnt <= '0;
          else if (wait_cnt == GAP_LAST)
          begin
            wait_cnt <= '0;
            if (state == GAP_LO)
              state <= IDLE;
            else if (is_write)
              state <= SEND_LO;
            else
              state <= WAIT_RSP;
          end
          else
            wait_cnt <= wait_cnt + wait_cnt_t'(1);
        end
        WAIT_RSP:
        begin
          if (rx_in.valid)
            state <= RESPOND;
          else if (wait_cnt == RSP_LAST)
          begin
            state    <= RECV;
            wait_cnt <= '0;
          end
          else
            wait_cnt <= wait_cnt + wait_cnt_t'(1);
        end
        RECV:
        begin
          if (rx_in.valid || grace_end)
            state <= RESPOND;
          else
            wait_cnt <= wait_cnt + wait_cnt_t'(1);
        end
        RESPOND:
          if (rsp_ready)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && cmd_valid)
      cmd_q <= cmd_data;

    if (rx_take)
    begin
      rsp_data       <= rx_in.data;
      rsp_parity_err <= rx_in.parity_err;
      rsp_frame_err  <= rx_in.frame_err;
      rsp_timeout    <= 1'b0;
    end
    else if (grace_end)
    begin
      rsp_data       <= '0;  // Silent device.
      rsp_parity_err <= 1'b0;
      rsp_frame_err  <= 1'b0;
      rsp_timeout    <= 1'b1;
    end
  end

endmodule

/* hdl/uart_frame_rx.sv */
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_frame_rx import uart_cmd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  rx_byte_if.source   rx_out
);

  localparam baud_cnt_t BIT_LAST = baud_cnt_t'(`UART_BAUD_DIV - 1);
  localparam baud_cnt_t SAMPLE   = baud_cnt_t'(`UART_SAMPLE_POINT);
  localparam logic [3:0] PAR_IDX  = 4'd9;
  localparam logic [3:0] STOP_IDX = 4'd10;

  logic       rx_s1;
  logic       rx_s2;
  logic       rx_prev;
  logic       start_edge;
  logic       busy;
  logic       sample_now;
  baud_cnt_t  baud_cnt;
  logic [3:0] bit_cnt;  // 0 start, 1..8 data, 9 parity, 10 stop.
  byte_t      shreg;
  logic       par_bit;

  assign start_edge = rx_prev & ~rx_s2;
  assign sample_now = busy && (baud_cnt == SAMPLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy         <= 1'b0;
      baud_cnt     <= '0;
      bit_cnt      <= '0;
      rx_out.valid <= 1'b0;
    end
    else
    begin
      rx_out.valid <= 1'b0;
      if (!busy)
      begin
        if (start_edge)
        begin
          busy     <= 1'b1;
          baud_cnt <= baud_cnt_t'(1);  // Edge cycle counts as zero.
          bit_cnt  <= '0;
        end
      end
      else
      begin
        if (baud_cnt == BIT_LAST)
        begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 4'd1;
        end
        else
          baud_cnt <= baud_cnt + baud_cnt_t'(1);

        if (sample_now && bit_cnt == 4'd0 && rx_s2)
          busy <= 1'b0;  // Glitch, not a start bit.
        else if (sample_now && bit_cnt == STOP_IDX)
        begin
          busy         <= 1'b0;
          rx_out.valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample_now)
    begin
      case (bit_cnt)
        4'd0: ;
        PAR_IDX:
          par_bit <= rx_s2;
        STOP_IDX:
        begin
          rx_out.data       <= shreg;
          rx_out.parity_err <= ~^{shreg, par_bit};  // Even count of ones.
          rx_out.frame_err  <= ~rx_s2;
        end
        default:
          shreg <= {rx_s2, shreg[7:1]};  // LSB arrives first.
      endcase
    end
  end

endmodule

/* hdl/uart_frame_tx.sv */
`timescale 1ns/10ps
`include "uart_cmd_defines.svh"

module uart_frame_tx import uart_cmd_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_valid,
  input  byte_t tx_byte,
  output logic  tx_ready,
  output logic  tx
);

  localparam baud_cnt_t BIT_LAST = baud_cnt_t'(`UART_BAUD_DIV - 1);
  localparam logic [3:0] STOP_IDX = 4'd10;

  logic [10:0] frame_sr;  // Stop, parity, data, start; bit 0 on the line.
  logic        busy;
  baud_cnt_t   baud_cnt;
  logic [3:0]  bit_cnt;
  logic        parity;

  // Odd parity over the data byte.
  assign parity   = ~^tx_byte;
  assign tx       = frame_sr[0];
  assign tx_ready = ~busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_sr <= '1;  // Line idles high.
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (!busy)
    begin
      if (tx_valid)
      begin
        frame_sr <= {1'b1, parity, tx_byte, 1'b0};
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end
    else if (baud_cnt == BIT_LAST)
    begin
      baud_cnt <= '0;
      frame_sr <= {1'b1, frame_sr[10:1]};  // Refill with idle level.
      if (bit_cnt == STOP_IDX)
        busy <= 1'b0;
      else
        bit_cnt <= bit_cnt + 4'd1;
    end
    else
    begin
      baud_cnt <= baud_cnt + baud_cnt_t'(1);
    end
  end

endmodule

/* hdl/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] cmd_t;      // Bit 15 write, 14:8 address, 7:0 data.
  typedef logic [6:0]  reg_addr_t;
  typedef logic [11:0] baud_cnt_t; // Clock within bit.
  typedef logic [9:0]  wait_cnt_t; // Gap and timeout.

  typedef enum logic [2:0] {
    IDLE,
    SEND_HI,
    GAP_HI,
    SEND_LO,
    GAP_LO,
    WAIT_RSP,
    RECV,
    RESPOND
  } ctrl_state_t;

endpackage

/* hdl/uart_cmd_defines.svh */
`ifndef UART_CMD_DEFINES_SVH
`define UART_CMD_DEFINES_SVH

// Clocks per serial bit; 434 for 115200 baud at 50 MHz.
`define UART_BAUD_DIV 16

// Clock count inside a bit where rx is sampled.
`define UART_SAMPLE_POINT (`UART_BAUD_DIV / 2)

// Idle cycles with tx high after each frame.
`define UART_GAP_CYCLES 32

// Cycles allowed for the read response to start.
`define UART_RESP_TIMEOUT 512

`endif
